//--- design/tpu_pkg.sv
// Data service package: shared word types, command fields, memory request and FSM states
`default_nettype none

package tpu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0]	data_t;
	typedef logic [9:0]		addr_t;
	typedef logic [15:0]	length_t;
	typedef logic [7:0]		stride_t;

	// Command word layout
	localparam int CMD_DIR_BIT		= 0;
	localparam int CMD_STRIDE_LSB	= 8;
	localparam int CMD_STRIDE_MSB	= 15;

	////////////////////////////////////////////////////////////////////////////
	// Transfer descriptor and memory request
	////////////////////////////////////////////////////////////////////////////

	// direction high means load (memory to extern)
	typedef struct packed {
		logic		direction;
		stride_t	stride;
		length_t	length;
		addr_t		base;
	} descriptor_t;

	typedef struct packed {
		logic		write;
		addr_t		addr;
		data_t		data;
	} mem_req_t;

	// Header capture states
	typedef enum logic [1:0] {
		HEADER_COMMAND,
		HEADER_LENGTH,
		HEADER_BASE,
		HEADER_ACTIVE
	} header_state_t;

	// Service states
	typedef enum logic [1:0] {
		SERVICE_IDLE,
		SERVICE_STORE,
		SERVICE_LOAD,
		SERVICE_DRAIN
	} service_state_t;

endpackage

`default_nettype wire

//--- design/service_descriptor.sv
// Descriptor capture: takes command, length and base words, then passes data words to the service
`default_nettype none

module service_descriptor (
	input	logic					clock,
	input	logic					reset,
	input	logic					in_valid,
	input	tpu_pkg::data_t			in_data,
	output	logic					in_ready,
	output	logic					desc_valid,
	output	tpu_pkg::descriptor_t	desc,
	output	logic					word_valid,
	output	tpu_pkg::data_t			word_data,
	input	logic					word_ready,
	input	logic					service_done
);

	tpu_pkg::header_state_t state;
	logic active;

	assign active = (state == tpu_pkg::HEADER_ACTIVE);

	// Header words are always taken; data words follow the service
	assign in_ready		= active ? word_ready : 1'b1;
	assign word_valid	= in_valid && active;
	assign word_data	= in_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= tpu_pkg::HEADER_COMMAND;
			desc_valid	<= 1'b0;
		end else begin
			case (state)
				tpu_pkg::HEADER_COMMAND: begin
					if (in_valid) state <= tpu_pkg::HEADER_LENGTH;
				end
				tpu_pkg::HEADER_LENGTH: begin
					if (in_valid) state <= tpu_pkg::HEADER_BASE;
				end
				tpu_pkg::HEADER_BASE: begin
					if (in_valid) begin
						state		<= tpu_pkg::HEADER_ACTIVE;
						desc_valid	<= 1'b1;
					end
				end
				default: begin
					if (service_done) begin
						state		<= tpu_pkg::HEADER_COMMAND;
						desc_valid	<= 1'b0;
					end
				end
			endcase
		end
	end

	// Descriptor fields
	always_ff @(posedge clock) begin
		if (in_valid) begin
			case (state)
				tpu_pkg::HEADER_COMMAND: begin
					desc.direction	<= in_data[tpu_pkg::CMD_DIR_BIT];
					desc.stride		<= in_data[tpu_pkg::CMD_STRIDE_MSB:tpu_pkg::CMD_STRIDE_LSB];
				end
				tpu_pkg::HEADER_LENGTH:	desc.length <= tpu_pkg::length_t'(in_data);
				tpu_pkg::HEADER_BASE:	desc.base <= tpu_pkg::addr_t'(in_data);
				default: ;
			endcase
		end
	end

	// Service relies on a steady descriptor for the whole transfer
	a_desc_stable: assert property (@(posedge clock) disable iff (reset)
		desc_valid |=> !desc_valid || $stable(desc));

endmodule

`default_nettype wire

//--- design/ring_buffer_ctrl.sv
// Ring buffer control: wrapping read and write pointers with fill count, full and empty
`default_nettype none

module ring_buffer_ctrl #(
	parameter int BUFF_SIZE = 16
) (
	input	logic							clock,
	input	logic							reset,
	input	logic							push,
	input	logic							pop,
	output	logic [$clog2(BUFF_SIZE)-1:0]	wr_ptr,
	output	logic [$clog2(BUFF_SIZE)-1:0]	rd_ptr,
	output	logic							full,
	output	logic							empty,
	output	logic [$clog2(BUFF_SIZE):0]		count
);

	localparam int IDX_W = $clog2(BUFF_SIZE);
	localparam int CNT_W = IDX_W + 1;

	assign full		= (count == CNT_W'(BUFF_SIZE));
	assign empty	= (count == '0);

	// Pointers wrap on their own since BUFF_SIZE is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + IDX_W'(1);
			if (pop) rd_ptr <= rd_ptr + IDX_W'(1);
			case ({push, pop})
				2'b10:		count <= count + CNT_W'(1);
				2'b01:		count <= count - CNT_W'(1);
				default:	count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// The service must keep its flow control inside the buffer bounds
	////////////////////////////////////////////////////////////////////////////

	a_no_push_full: assert property (@(posedge clock) disable iff (reset)
		push |-> !full);

	a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
		pop |-> !empty);

endmodule

`default_nettype wire

//--- design/data_service.sv
// Data service: store and load FSM, ring buffer storage and strided memory requests
`default_nettype none

module data_service #(
	parameter int BUFF_SIZE = 16
) (
	input	logic					clock,
	input	logic					reset,
	input	logic					desc_valid,
	input	tpu_pkg::descriptor_t	desc,
	output	logic					service_done,
	input	logic					word_valid,
	input	tpu_pkg::data_t			word_data,
	output	logic					word_ready,
	output	logic					out_valid,
	output	tpu_pkg::data_t			out_data,
	input	logic					out_ready,
	output	logic					mem_req_valid,
	output	tpu_pkg::mem_req_t		mem_req,
	input	logic					rd_valid,
	input	tpu_pkg::data_t			rd_data
);

	localparam int IDX_W = $clog2(BUFF_SIZE);
	localparam int CNT_W = IDX_W + 1;

	tpu_pkg::service_state_t state;
	tpu_pkg::data_t buff [BUFF_SIZE];
	tpu_pkg::addr_t addr_q;
	tpu_pkg::length_t acc_cnt;
	tpu_pkg::length_t done_cnt;

	logic [IDX_W-1:0] wr_ptr;
	logic [IDX_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic empty;
	logic push;
	logic pop;
	logic busy;
	logic word_accept;
	logic store_write;
	logic rd_issue;
	logic rd_pending;
	logic last_accept;
	logic last_done;

	assign busy			= (state != tpu_pkg::SERVICE_IDLE);
	assign last_accept	= (acc_cnt == desc.length - tpu_pkg::length_t'(1));
	assign last_done	= (done_cnt == desc.length - tpu_pkg::length_t'(1));

	// Store path
	assign word_ready	= (state == tpu_pkg::SERVICE_STORE) && !full;
	assign word_accept	= word_valid && word_ready;
	assign store_write	= busy && !desc.direction && !empty;

	// Load path, one read can be in flight
	assign rd_issue = (state == tpu_pkg::SERVICE_LOAD)
		&& (({1'b0, count} + (CNT_W + 1)'(rd_pending)) < (CNT_W + 1)'(BUFF_SIZE));
	assign out_valid	= busy && desc.direction && !empty;
	assign out_data		= buff[rd_ptr];

	assign push	= word_accept || rd_valid;
	assign pop	= store_write || (out_valid && out_ready);

	assign mem_req_valid	= store_write || rd_issue;
	assign mem_req.write	= store_write;
	assign mem_req.addr		= addr_q;
	assign mem_req.data		= buff[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) buff[wr_ptr] <= rd_valid ? rd_data : word_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Service FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state			<= tpu_pkg::SERVICE_IDLE;
			service_done	<= 1'b0;
			rd_pending		<= 1'b0;
			acc_cnt			<= '0;
			done_cnt		<= '0;
		end else begin
			service_done	<= 1'b0;
			rd_pending		<= rd_issue;
			if (word_accept || rd_issue) acc_cnt <= acc_cnt + tpu_pkg::length_t'(1);
			if (pop) done_cnt <= done_cnt + tpu_pkg::length_t'(1);
			case (state)
				tpu_pkg::SERVICE_IDLE: begin
					acc_cnt		<= '0;
					done_cnt	<= '0;
					// Done pulse still visible here, descriptor drops next edge
					if (desc_valid && !service_done) begin
						if (desc.length == '0) service_done <= 1'b1;
						else if (desc.direction) state <= tpu_pkg::SERVICE_LOAD;
						else state <= tpu_pkg::SERVICE_STORE;
					end
				end
				tpu_pkg::SERVICE_STORE: begin
					if (word_accept && last_accept) state <= tpu_pkg::SERVICE_DRAIN;
				end
				tpu_pkg::SERVICE_LOAD: begin
					if (rd_issue && last_accept) state <= tpu_pkg::SERVICE_DRAIN;
				end
				default: begin
					// Wait for the final write or output handshake
					if (pop && last_done) begin
						service_done	<= 1'b1;
						state			<= tpu_pkg::SERVICE_IDLE;
					end
				end
			endcase
		end
	end

	// Strided address, wraps at the memory size
	always_ff @(posedge clock) begin
		if (state == tpu_pkg::SERVICE_IDLE) addr_q <= desc.base;
		else if (mem_req_valid) addr_q <= addr_q + tpu_pkg::addr_t'(desc.stride);
	end

	ring_buffer_ctrl #(
		.BUFF_SIZE	(BUFF_SIZE)
	) u_ring_buffer_ctrl (
		.clock		(clock),
		.reset		(reset),
		.push		(push),
		.pop		(pop),
		.wr_ptr		(wr_ptr),
		.rd_ptr		(rd_ptr),
		.full		(full),
		.empty		(empty),
		.count		(count)
	);

	// Memory answers only reads issued the cycle before
	a_rd_in_flight: assert property (@(posedge clock) disable iff (reset)
		rd_valid |-> rd_pending);

endmodule

`default_nettype wire

//--- design/data_memory.sv
// Data memory: 1024-word single-port array with a fixed one-cycle read response
`default_nettype none

module data_memory (
	input	logic				clock,
	input	logic				mem_req_valid,
	input	tpu_pkg::mem_req_t	mem_req,
	output	logic				rd_valid,
	output	tpu_pkg::data_t		rd_data
);

	tpu_pkg::data_t mem [1024];

	// Write side
	always_ff @(posedge clock) begin
		if (mem_req_valid && mem_req.write) begin
			mem[mem_req.addr] <= mem_req.data;
		end
	end

	// Read data, no read-during-write forwarding needed on a single port
	always_ff @(posedge clock) begin
		if (mem_req_valid && !mem_req.write) begin
			rd_data <= mem[mem_req.addr];
		end
	end

	// Response strobe follows the request valid, which reset holds low
	always_ff @(posedge clock) begin
		rd_valid <= mem_req_valid && !mem_req.write;
	end

endmodule

`default_nettype wire

//--- design/data_service_top.sv
// Data service top: descriptor capture, service with ring buffer, and local data memory
`default_nettype none

module data_service_top #(
	parameter int BUFF_SIZE = 16
) (
	input	logic				clock,
	input	logic				reset,
	input	logic				in_valid,
	input	tpu_pkg::data_t		in_data,
	output	logic				in_ready,
	output	logic				out_valid,
	output	tpu_pkg::data_t		out_data,
	input	logic				out_ready
);

	tpu_pkg::descriptor_t desc;
	tpu_pkg::mem_req_t mem_req;
	tpu_pkg::data_t word_data;
	tpu_pkg::data_t rd_data;
	logic desc_valid;
	logic service_done;
	logic word_valid;
	logic word_ready;
	logic mem_req_valid;
	logic rd_valid;

	service_descriptor u_service_descriptor (
		.clock			(clock),
		.reset			(reset),
		.in_valid		(in_valid),
		.in_data		(in_data),
		.in_ready		(in_ready),
		.desc_valid		(desc_valid),
		.desc			(desc),
		.word_valid		(word_valid),
		.word_data		(word_data),
		.word_ready		(word_ready),
		.service_done	(service_done)
	);

	data_service #(
		.BUFF_SIZE		(BUFF_SIZE)
	) u_data_service (
		.clock			(clock),
		.reset			(reset),
		.desc_valid		(desc_valid),
		.desc			(desc),
		.service_done	(service_done),
		.word_valid		(word_valid),
		.word_data		(word_data),
		.word_ready		(word_ready),
		.out_valid		(out_valid),
		.out_data		(out_data),
		.out_ready		(out_ready),
		.mem_req_valid	(mem_req_valid),
		.mem_req		(mem_req),
		.rd_valid		(rd_valid),
		.rd_data		(rd_data)
	);

	data_memory u_data_memory (
		.clock			(clock),
		.mem_req_valid	(mem_req_valid),
		.mem_req		(mem_req),
		.rd_valid		(rd_valid),
		.rd_data		(rd_data)
	);

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
// Clock and reset source for the data service testbench
`default_nettype none

module clock_gen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Released on a falling edge, like every other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- sim/service_checker.sv
// Output checker: compares output words with the expected queue and watches the input during loads
`default_nettype none

module service_checker (
	input	logic				clock,
	input	logic				reset,
	input	logic				in_valid,
	input	logic				in_ready,
	input	tpu_pkg::data_t		in_data,
	input	logic				out_valid,
	input	logic				out_ready,
	input	tpu_pkg::data_t		out_data,
	input	logic				load_busy,
	input	logic				exp_push,
	input	tpu_pkg::data_t		exp_data,
	output	int					expected_left,
	output	int					error_count
);

	timeunit 1ns;
	timeprecision 1ps;

	tpu_pkg::data_t expected_q [$];
	tpu_pkg::data_t expected;

	always @(posedge clock) begin
		if (reset) begin
			expected_q.delete();
			error_count = 0;
		end else begin
			if (exp_push) expected_q.push_back(exp_data);

			if (out_valid && out_ready) begin
				if (expected_q.size() == 0) begin
					$display("%0t: output word %h arrived while no word was expected",
						$time, out_data);
					error_count = error_count + 1;
				end else begin
					expected = expected_q.pop_front();
					if (out_data !== expected) begin
						$display("FAILED out_data: expected %h, received %h", expected, out_data);
						error_count = error_count + 1;
					end
				end
			end

			// Input stream stays closed from a load's base word to its last output
			if (load_busy && in_valid && in_ready) begin
				$display("%0t: input word %h was accepted while a load was running",
					$time, in_data);
				error_count = error_count + 1;
			end
		end
		expected_left = expected_q.size();
	end

endmodule

`default_nettype wire

//--- sim/tb_data_service.sv
// Data service testbench: drives store and load transfers and predicts the loaded words
`default_nettype none

module tb_data_service;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BUFF_SIZE = 16;
	localparam int MEM_WORDS = 1024;
	localparam logic [31:0] SEED = 32'h396c;
	// About 200 words at up to 25 cycles each, plus headers and margin
	localparam int TIMEOUT_CYCLES = 200 * 25 + 1000;

	logic clock;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	logic exp_push;
	logic load_busy;
	tpu_pkg::data_t in_data;
	tpu_pkg::data_t out_data;
	tpu_pkg::data_t exp_data;
	int expected_left;
	int error_count;
	int tb_errors;
	int out_seen;
	int load_out_target;
	int cycle_count;
	logic [31:0] rng;
	logic [31:0] ready_rng;

	// Reference copy of the data memory
	tpu_pkg::data_t model_mem [MEM_WORDS];

	clock_gen #(
		.PERIOD			(20),
		.RESET_CYCLES	(10)
	) u_clock_gen (
		.clock			(clock),
		.reset			(reset)
	);

	data_service_top #(
		.BUFF_SIZE		(BUFF_SIZE)
	) DUT (
		.clock			(clock),
		.reset			(reset),
		.in_valid		(in_valid),
		.in_data		(in_data),
		.in_ready		(in_ready),
		.out_valid		(out_valid),
		.out_data		(out_data),
		.out_ready		(out_ready)
	);

	service_checker u_service_checker (
		.clock			(clock),
		.reset			(reset),
		.in_valid		(in_valid),
		.in_ready		(in_ready),
		.in_data		(in_data),
		.out_valid		(out_valid),
		.out_ready		(out_ready),
		.out_data		(out_data),
		.load_busy		(load_busy),
		.exp_push		(exp_push),
		.exp_data		(exp_data),
		.expected_left	(expected_left),
		.error_count	(error_count)
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Word i of a transfer sits at base + i * stride, modulo the memory size
	function automatic tpu_pkg::data_t expected_word(input int base, input int stride,
		input int index);
		tpu_pkg::addr_t addr;
		addr = tpu_pkg::addr_t'((base + index * stride) % MEM_WORDS);
		return model_mem[addr];
	endfunction

	task automatic insert_gap();
		int idle;
		rng = next_random(rng);
		idle = (rng[2:0] < 3'd3) ? int'(rng[4:3]) + 1 : 0;
		repeat (idle) @(negedge clock);
	endtask

	// Valid is held until the word is taken
	task automatic send_word(input tpu_pkg::data_t word);
		logic accepted;
		insert_gap();
		in_valid = 1'b1;
		in_data = word;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clock);
			accepted = in_ready;
			@(negedge clock);
		end
		in_valid = 1'b0;
	endtask

	task automatic send_header(input logic load, input int stride, input int length,
		input int base);
		tpu_pkg::data_t command;
		rng = next_random(rng);
		// Unused command bits carry noise
		command = rng;
		command[tpu_pkg::CMD_DIR_BIT] = load;
		command[tpu_pkg::CMD_STRIDE_MSB:tpu_pkg::CMD_STRIDE_LSB] = tpu_pkg::stride_t'(stride);
		send_word(command);
		send_word(tpu_pkg::data_t'(length));
		send_word(tpu_pkg::data_t'(base));
	endtask

	task automatic push_expected(input tpu_pkg::data_t word);
		exp_push = 1'b1;
		exp_data = word;
		@(negedge clock);
		exp_push = 1'b0;
	endtask

	task automatic store_block(input int base, input int stride, input int length);
		tpu_pkg::addr_t addr;
		int i;
		send_header(1'b0, stride, length, base);
		for (i = 0; i < length; i++) begin
			rng = next_random(rng);
			addr = tpu_pkg::addr_t'((base + i * stride) % MEM_WORDS);
			model_mem[addr] = rng;
			send_word(rng);
		end
	endtask

	// Returns after the base word, so the next header waits on the running load
	task automatic load_block(input int base, input int stride, input int length);
		int i;
		for (i = 0; i < length; i++) begin
			push_expected(expected_word(base, stride, i));
		end
		send_header(1'b1, stride, length, base);
		load_out_target = load_out_target + length;
	endtask

	always @(posedge clock) begin
		if (reset) out_seen <= 0;
		else if (out_valid && out_ready) out_seen <= out_seen + 1;
	end

	assign load_busy = (out_seen < load_out_target);

	// Output back-pressure from its own random stream
	initial begin : ready_toggle
		ready_rng = ~SEED;
		out_ready = 1'b0;
		forever begin
			@(negedge clock);
			ready_rng = next_random(ready_rng);
			out_ready = (ready_rng[1:0] != 2'b00);
		end
	end

	initial begin : stimulus
		rng = SEED;
		in_valid = 1'b0;
		in_data = '0;
		exp_push = 1'b0;
		exp_data = '0;
		load_out_target = 0;
		tb_errors = 0;
		@(posedge clock);
		while (reset) @(posedge clock);
		@(negedge clock);
		if (in_ready !== 1'b1) begin
			$display("FAILED in_ready after reset: expected %h, received %h", 1'b1, in_ready);
			tb_errors++;
		end
		if (out_valid !== 1'b0) begin
			$display("FAILED out_valid after reset: expected %h, received %h", 1'b0, out_valid);
			tb_errors++;
		end

		store_block(100, 1, 12);
		load_block(100, 1, 12);
		load_block(100, 2, 6);
		// Longer than the ring buffer
		store_block(300, 1, 40);
		load_block(300, 1, 40);
		// Wraps past address 1023
		store_block(1000, 3, 20);
		load_block(1000, 3, 20);
		// Empty store writes nothing
		store_block(100, 1, 0);
		load_block(100, 3, 4);

		// Input reopens once the last load has finished
		while (!in_ready) @(negedge clock);
		repeat (4) @(negedge clock);
		if (expected_left != 0) begin
			$display("%0d expected words were never received", expected_left);
			tb_errors++;
		end
		$display("Errors: %0d in output checks, %0d in testbench checks", error_count, tb_errors);
		if (error_count + tb_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with %0d expected words still queued",
			TIMEOUT_CYCLES, expected_left);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/tpu_pkg.sv
design/service_descriptor.sv
design/ring_buffer_ctrl.sv
design/data_service.sv
design/data_memory.sv
design/data_service_top.sv
sim/clock_gen.sv
sim/service_checker.sv
sim/tb_data_service.sv

//--- run.sh
#!/usr/bin/env bash
# Build the data service testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
	&& verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_data_service -f list.f -o tb_data_service \
	&& ./obj_dir/tb_data_service | tee sim.log \
	&& grep -q "^\*\*\* PASSED \*\*\*$" sim.log \
	&& echo "Simulation run passed" \
	|| { echo "Simulation run failed"; exit 1; }
